// ==== common/ppc_decode_pkg.sv ====
// decode stage shared definitions

package ppc_decode_pkg;

    localparam int INSTR_W    = 32;
    localparam int REG_ADDR_W = 5;
    localparam int CR_BIT_W   = 5;
    localparam int CR_FIELD_W = 3;
    localparam int LI_W       = 24;
    localparam int BD_W       = 14;
    localparam int BO_W       = 5;
    localparam int BH_W       = 2;
    localparam int LEV_W      = 7;
    localparam int SH_W       = 5;
    localparam int XO_W       = 10;
    localparam int DATA_W     = 32;

    // primary opcodes
    localparam logic [5:0] OPCD_BC     = 6'd16;
    localparam logic [5:0] OPCD_SC     = 6'd17;
    localparam logic [5:0] OPCD_B      = 6'd18;
    localparam logic [5:0] OPCD_XL     = 6'd19;
    localparam logic [5:0] OPCD_RLWIMI = 6'd20;
    localparam logic [5:0] OPCD_RLWINM = 6'd21;
    localparam logic [5:0] OPCD_RLWNM  = 6'd23;
    localparam logic [5:0] OPCD_X      = 6'd31;

    // XL-form extended opcodes
    localparam logic [XO_W-1:0] XO_BCLR   = 10'd16;
    localparam logic [XO_W-1:0] XO_BCCTR  = 10'd528;
    localparam logic [XO_W-1:0] XO_MCRF   = 10'd0;
    localparam logic [XO_W-1:0] XO_CRNOR  = 10'd33;
    localparam logic [XO_W-1:0] XO_CRANDC = 10'd129;
    localparam logic [XO_W-1:0] XO_CRXOR  = 10'd193;
    localparam logic [XO_W-1:0] XO_CRAND  = 10'd257;
    localparam logic [XO_W-1:0] XO_CREQV  = 10'd289;
    localparam logic [XO_W-1:0] XO_CRORC  = 10'd417;
    localparam logic [XO_W-1:0] XO_CROR   = 10'd449;

    // XO-form, OE bit not included
    localparam logic [XO_W-2:0] XO_SUBFC  = 9'd8;
    localparam logic [XO_W-2:0] XO_ADDC   = 9'd10;
    localparam logic [XO_W-2:0] XO_SUBF   = 9'd40;
    localparam logic [XO_W-2:0] XO_NEG    = 9'd104;
    localparam logic [XO_W-2:0] XO_SUBFE  = 9'd136;
    localparam logic [XO_W-2:0] XO_ADDE   = 9'd138;
    localparam logic [XO_W-2:0] XO_SUBFZE = 9'd200;
    localparam logic [XO_W-2:0] XO_ADDZE  = 9'd202;
    localparam logic [XO_W-2:0] XO_SUBFME = 9'd232;
    localparam logic [XO_W-2:0] XO_ADDME  = 9'd234;
    localparam logic [XO_W-2:0] XO_ADD    = 9'd266;

    localparam logic [XO_W-1:0] XO_CMP    = 10'd0;
    localparam logic [XO_W-1:0] XO_CMPL   = 10'd32;

    typedef enum logic [1:0] {
        BR_EXEC_NONE,
        BR_EXEC_BRANCH,
        BR_EXEC_SYSCALL,
        BR_EXEC_COND
    } branch_exec_t;

    typedef enum logic [1:0] {
        BRANCH_UNCOND,
        BRANCH_COND,
        BRANCH_LR,
        BRANCH_CTR
    } branch_op_t;

    typedef enum logic [2:0] {
        COND_MOVE, COND_AND, COND_OR, COND_XOR,
        COND_NOR, COND_ANDC, COND_ORC, COND_EQV
    } cond_op_t;

    typedef enum logic [1:0] {
        FX_EXEC_NONE,
        FX_EXEC_ROTATE,
        FX_EXEC_ADD_SUB,
        FX_EXEC_COMPARE
    } fx_exec_t;

endpackage

// ==== branch/branch_decoder.sv ====
// branch and condition register decode
`timescale 1ns/1ps

module branch_decoder import ppc_decode_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic [0:INSTR_W-1]    instruction,
    output branch_exec_t          branch_execute,
    output branch_op_t            branch_op,
    output logic                  lk,
    output logic                  aa,
    output logic [LI_W-1:0]       li,
    output logic [BD_W-1:0]       bd,
    output logic [CR_BIT_W-1:0]   bi,
    output logic [BO_W-1:0]       bo,
    output logic [BH_W-1:0]       bh,
    output logic [LEV_W-1:0]      sc_lev,
    output cond_op_t              cond_op,
    output logic [CR_BIT_W-1:0]   cr_ba,
    output logic [CR_BIT_W-1:0]   cr_bb,
    output logic [CR_BIT_W-1:0]   cr_bt
);

    logic [5:0]          opcd;
    logic [XO_W-1:0]     xl_xo;
    branch_exec_t        exec_d;
    branch_op_t          op_d;
    cond_op_t            cond_d;
    logic                lk_d, aa_d;
    logic [LI_W-1:0]     li_d;
    logic [BD_W-1:0]     bd_d;
    logic [CR_BIT_W-1:0] bi_d, ba_d, bb_d, bt_d;
    logic [BO_W-1:0]     bo_d;
    logic [BH_W-1:0]     bh_d;
    logic [LEV_W-1:0]    lev_d;

    assign opcd  = instruction[0:5];
    assign xl_xo = instruction[21:30];

    always_comb
    begin
        exec_d = BR_EXEC_NONE;
        op_d   = BRANCH_UNCOND;
        cond_d = COND_MOVE;
        lk_d   = 1'b0;
        aa_d   = 1'b0;
        li_d   = '0;
        bd_d   = '0;
        bi_d   = '0;
        bo_d   = '0;
        bh_d   = '0;
        lev_d  = '0;
        ba_d   = '0;
        bb_d   = '0;
        bt_d   = '0;
        case (opcd)
            OPCD_BC:
            begin
                exec_d = BR_EXEC_BRANCH;
                op_d   = BRANCH_COND;
                bo_d   = instruction[6:10];
                bi_d   = instruction[11:15];
                bd_d   = instruction[16:29];
                aa_d   = instruction[30];
                lk_d   = instruction[31];
            end
            OPCD_SC:
            begin
                if (instruction[30]) // always-one bit
                begin
                    exec_d = BR_EXEC_SYSCALL;
                    lev_d  = instruction[20:26];
                end
            end
            OPCD_B:
            begin
                exec_d = BR_EXEC_BRANCH;
                li_d   = instruction[6:29];
                aa_d   = instruction[30];
                lk_d   = instruction[31];
            end
            OPCD_XL:
            begin
                case (xl_xo)
                    XO_BCLR, XO_BCCTR:
                    begin
                        exec_d = BR_EXEC_BRANCH;
                        if (xl_xo == XO_BCLR)
                            op_d = BRANCH_LR;
                        else
                            op_d = BRANCH_CTR;
                        bo_d = instruction[6:10];
                        bi_d = instruction[11:15];
                        bh_d = instruction[19:20];
                        lk_d = instruction[31];
                    end
                    XO_MCRF, XO_CRNOR, XO_CRANDC, XO_CRXOR,
                    XO_CRAND, XO_CREQV, XO_CRORC, XO_CROR:
                    begin
                        exec_d = BR_EXEC_COND;
                        bt_d   = instruction[6:10];
                        ba_d   = instruction[11:15];
                        bb_d   = instruction[16:20];
                        case (xl_xo)
                            XO_CRAND:  cond_d = COND_AND;
                            XO_CROR:   cond_d = COND_OR;
                            XO_CRXOR:  cond_d = COND_XOR;
                            XO_CRNOR:  cond_d = COND_NOR;
                            XO_CRANDC: cond_d = COND_ANDC;
                            XO_CRORC:  cond_d = COND_ORC;
                            XO_CREQV:  cond_d = COND_EQV;
                            default:   cond_d = COND_MOVE; // mcrf
                        endcase
                    end
                    default: ;
                endcase
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            branch_execute <= BR_EXEC_NONE;
            branch_op      <= BRANCH_UNCOND;
            cond_op        <= COND_MOVE;
            {lk, aa, li, bd, bi, bo, bh} <= '0;
            {sc_lev, cr_ba, cr_bb, cr_bt} <= '0;
        end
        else
        begin
            branch_execute <= exec_d;
            branch_op      <= op_d;
            cond_op        <= cond_d;
            {lk, aa, li, bd, bi, bo, bh} <= {lk_d, aa_d, li_d, bd_d, bi_d, bo_d, bh_d};
            {sc_lev, cr_ba, cr_bb, cr_bt} <= {lev_d, ba_d, bb_d, bt_d};
        end
    end

    a_branch_fields_idle: assert property (@(posedge clk)
        branch_execute != BR_EXEC_BRANCH |-> branch_op == BRANCH_UNCOND && !lk && !aa
            && li == '0 && bd == '0 && bi == '0 && bo == '0 && bh == '0)
        else $error("branch fields set outside a branch");

endmodule

// ==== fixed_point/fx_rotate_decoder.sv ====
// M-form rotate decode
`timescale 1ns/1ps

module fx_rotate_decoder import ppc_decode_pkg::*;
(
    input  logic [0:INSTR_W-1]    instruction,
    output logic                  hit,
    output logic [REG_ADDR_W-1:0] op1_reg,
    output logic [REG_ADDR_W-1:0] op2_reg,
    output logic [REG_ADDR_W-1:0] result_reg,
    output logic                  op2_use_imm,
    output logic [DATA_W-1:0]     op2_immediate,
    output logic [SH_W-1:0]       mb,
    output logic [SH_W-1:0]       me,
    output logic                  mask_insert,
    output logic                  alter_cr0
);

    logic [5:0] opcd;

    assign opcd = instruction[0:5];

    always_comb
    begin
        hit           = 1'b0;
        op1_reg       = '0;
        op2_reg       = '0;
        result_reg    = '0;
        op2_use_imm   = 1'b0;
        op2_immediate = '0;
        mb            = '0;
        me            = '0;
        mask_insert   = 1'b0;
        alter_cr0     = 1'b0;
        if (opcd == OPCD_RLWIMI || opcd == OPCD_RLWINM || opcd == OPCD_RLWNM)
        begin
            hit         = 1'b1;
            op1_reg     = instruction[6:10];  // RS
            result_reg  = instruction[11:15]; // RA
            mb          = instruction[21:25];
            me          = instruction[26:30];
            mask_insert = (opcd == OPCD_RLWIMI);
            alter_cr0   = instruction[31];
            if (opcd == OPCD_RLWNM)
                op2_reg = instruction[16:20]; // rotate count from RB
            else
            begin
                op2_use_imm   = 1'b1;
                op2_immediate = {{(DATA_W-SH_W){1'b0}}, instruction[16:20]};
            end
        end
    end

endmodule

// ==== fixed_point/fx_arith_decoder.sv ====
// add/subtract and compare decode
`timescale 1ns/1ps

module fx_arith_decoder import ppc_decode_pkg::*;
(
    input  logic [0:INSTR_W-1]    instruction,
    output logic                  hit,
    output logic                  is_compare,
    output logic [REG_ADDR_W-1:0] op1_reg,
    output logic [REG_ADDR_W-1:0] op2_reg,
    output logic [REG_ADDR_W-1:0] result_reg,
    output logic                  op2_use_imm,
    output logic [DATA_W-1:0]     op2_immediate,
    output logic                  subtract,
    output logic                  alter_ca,
    output logic                  alter_ov,
    output logic                  add_ca,
    output logic                  alter_cr0,
    output logic                  cmp_signed,
    output logic [CR_FIELD_W-1:0] bf
);

    logic [5:0]      opcd;
    logic [XO_W-1:0] x_xo;
    logic [XO_W-2:0] xo_xo;
    logic            cmp_hit;
    logic            xo_hit, sub_f, ca_f, ext_f, imm_f, ones_f;

    assign opcd    = instruction[0:5];
    assign x_xo    = instruction[21:30];
    assign xo_xo   = instruction[22:30]; // OE dropped
    assign cmp_hit = (opcd == OPCD_X) && (x_xo == XO_CMP || x_xo == XO_CMPL);

    // columns: hit, subtract, alter_ca, add_ca, immediate, all-ones
    always_comb
    begin
        case (xo_xo)
            XO_ADD:    {xo_hit, sub_f, ca_f, ext_f, imm_f, ones_f} = 6'b100000;
            XO_SUBF:   {xo_hit, sub_f, ca_f, ext_f, imm_f, ones_f} = 6'b110000;
            XO_ADDC:   {xo_hit, sub_f, ca_f, ext_f, imm_f, ones_f} = 6'b101000;
            XO_SUBFC:  {xo_hit, sub_f, ca_f, ext_f, imm_f, ones_f} = 6'b111000;
            XO_ADDE:   {xo_hit, sub_f, ca_f, ext_f, imm_f, ones_f} = 6'b101100;
            XO_SUBFE:  {xo_hit, sub_f, ca_f, ext_f, imm_f, ones_f} = 6'b111100;
            XO_NEG:    {xo_hit, sub_f, ca_f, ext_f, imm_f, ones_f} = 6'b110010;
            XO_ADDZE:  {xo_hit, sub_f, ca_f, ext_f, imm_f, ones_f} = 6'b101110;
            XO_SUBFZE: {xo_hit, sub_f, ca_f, ext_f, imm_f, ones_f} = 6'b111110;
            XO_ADDME:  {xo_hit, sub_f, ca_f, ext_f, imm_f, ones_f} = 6'b101111;
            XO_SUBFME: {xo_hit, sub_f, ca_f, ext_f, imm_f, ones_f} = 6'b111111;
            default:   {xo_hit, sub_f, ca_f, ext_f, imm_f, ones_f} = 6'b000000;
        endcase
    end

    always_comb
    begin
        hit           = 1'b0;
        is_compare    = 1'b0;
        op1_reg       = '0;
        op2_reg       = '0;
        result_reg    = '0;
        op2_use_imm   = 1'b0;
        op2_immediate = '0;
        {subtract, alter_ca, alter_ov, add_ca, alter_cr0} = '0;
        cmp_signed    = 1'b0;
        bf            = '0;
        if (cmp_hit)
        begin
            hit        = 1'b1;
            is_compare = 1'b1;
            op1_reg    = instruction[11:15];
            op2_reg    = instruction[16:20];
            cmp_signed = (x_xo == XO_CMP);
            bf         = instruction[6:8];
        end
        else if (opcd == OPCD_X && xo_hit)
        begin
            hit           = 1'b1;
            op1_reg       = instruction[11:15]; // RA
            result_reg    = instruction[6:10];  // RT
            op2_use_imm   = imm_f;
            op2_reg       = imm_f ? '0 : instruction[16:20];
            op2_immediate = ones_f ? '1 : '0;
            subtract      = sub_f;
            alter_ca      = ca_f;
            add_ca        = ext_f;
            alter_ov      = instruction[21];
            alter_cr0     = instruction[31];
        end
    end

endmodule

// ==== fixed_point/fixed_point_decoder.sv ====
// fixed-point decode and register
`timescale 1ns/1ps

module fixed_point_decoder import ppc_decode_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic [0:INSTR_W-1]    instruction,
    output fx_exec_t              fx_execute,
    output logic [REG_ADDR_W-1:0] op1_reg,
    output logic [REG_ADDR_W-1:0] op2_reg,
    output logic [REG_ADDR_W-1:0] result_reg,
    output logic                  op2_use_imm,
    output logic [DATA_W-1:0]     op2_immediate,
    output logic [SH_W-1:0]       mb,
    output logic [SH_W-1:0]       me,
    output logic                  mask_insert,
    output logic                  subtract,
    output logic                  alter_ca,
    output logic                  alter_ov,
    output logic                  add_ca,
    output logic                  alter_cr0,
    output logic                  cmp_signed,
    output logic [CR_FIELD_W-1:0] bf
);

    logic                  rot_hit, rot_imm, rot_insert, rot_cr0;
    logic [REG_ADDR_W-1:0] rot_op1, rot_op2, rot_res;
    logic [DATA_W-1:0]     rot_immediate;
    logic [SH_W-1:0]       rot_mb, rot_me;
    logic                  ari_hit, ari_cmp, ari_imm, ari_sub, ari_ca, ari_ov, ari_add_ca;
    logic                  ari_cr0, ari_signed;
    logic [REG_ADDR_W-1:0] ari_op1, ari_op2, ari_res;
    logic [DATA_W-1:0]     ari_immediate;
    logic [CR_FIELD_W-1:0] ari_bf;
    fx_exec_t              exec_d;

    fx_rotate_decoder rotate_i (
        .instruction(instruction), .hit(rot_hit),
        .op1_reg(rot_op1), .op2_reg(rot_op2), .result_reg(rot_res),
        .op2_use_imm(rot_imm), .op2_immediate(rot_immediate),
        .mb(rot_mb), .me(rot_me), .mask_insert(rot_insert), .alter_cr0(rot_cr0)
    );

    fx_arith_decoder arith_i (
        .instruction(instruction), .hit(ari_hit), .is_compare(ari_cmp),
        .op1_reg(ari_op1), .op2_reg(ari_op2), .result_reg(ari_res),
        .op2_use_imm(ari_imm), .op2_immediate(ari_immediate),
        .subtract(ari_sub), .alter_ca(ari_ca), .alter_ov(ari_ov), .add_ca(ari_add_ca),
        .alter_cr0(ari_cr0), .cmp_signed(ari_signed), .bf(ari_bf)
    );

    always_comb
    begin
        if (rot_hit)
            exec_d = FX_EXEC_ROTATE;
        else if (ari_hit && ari_cmp)
            exec_d = FX_EXEC_COMPARE;
        else if (ari_hit)
            exec_d = FX_EXEC_ADD_SUB;
        else
            exec_d = FX_EXEC_NONE;
    end

    // sub-decoders drive zeros on a miss
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            fx_execute <= FX_EXEC_NONE;
            {op1_reg, op2_reg, result_reg, op2_use_imm, op2_immediate} <= '0;
            {mb, me, mask_insert, subtract, alter_ca, alter_ov, add_ca} <= '0;
            {alter_cr0, cmp_signed, bf} <= '0;
        end
        else
        begin
            fx_execute    <= exec_d;
            op1_reg       <= rot_hit ? rot_op1 : ari_op1;
            op2_reg       <= rot_hit ? rot_op2 : ari_op2;
            result_reg    <= rot_hit ? rot_res : ari_res;
            op2_use_imm   <= rot_hit ? rot_imm : ari_imm;
            op2_immediate <= rot_hit ? rot_immediate : ari_immediate;
            alter_cr0     <= rot_hit ? rot_cr0 : ari_cr0;
            {mb, me, mask_insert} <= {rot_mb, rot_me, rot_insert};
            {subtract, alter_ca, alter_ov, add_ca} <= {ari_sub, ari_ca, ari_ov, ari_add_ca};
            {cmp_signed, bf} <= {ari_signed, ari_bf};
        end
    end

    a_single_hit: assert property (@(posedge clk) disable iff (rst) !(rot_hit && ari_hit))
        else $error("rotate and arithmetic decode both hit");

endmodule

// ==== design/ppc_decode_top.sv ====
// instruction decode stage top
`timescale 1ns/1ps

module ppc_decode_top import ppc_decode_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic [0:INSTR_W-1]    instruction,
    output branch_exec_t          branch_execute,
    output branch_op_t            branch_op,
    output logic                  lk,
    output logic                  aa,
    output logic [LI_W-1:0]       li,
    output logic [BD_W-1:0]       bd,
    output logic [CR_BIT_W-1:0]   bi,
    output logic [BO_W-1:0]       bo,
    output logic [BH_W-1:0]       bh,
    output logic [LEV_W-1:0]      sc_lev,
    output cond_op_t              cond_op,
    output logic [CR_BIT_W-1:0]   cr_ba,
    output logic [CR_BIT_W-1:0]   cr_bb,
    output logic [CR_BIT_W-1:0]   cr_bt,
    output fx_exec_t              fx_execute,
    output logic [REG_ADDR_W-1:0] op1_reg,
    output logic [REG_ADDR_W-1:0] op2_reg,
    output logic [REG_ADDR_W-1:0] result_reg,
    output logic                  op2_use_imm,
    output logic [DATA_W-1:0]     op2_immediate,
    output logic [SH_W-1:0]       mb,
    output logic [SH_W-1:0]       me,
    output logic                  mask_insert,
    output logic                  subtract,
    output logic                  alter_ca,
    output logic                  alter_ov,
    output logic                  add_ca,
    output logic                  alter_cr0,
    output logic                  cmp_signed,
    output logic [CR_FIELD_W-1:0] bf
);

    branch_decoder branch_i (
        .clk(clk), .rst(rst), .instruction(instruction),
        .branch_execute(branch_execute), .branch_op(branch_op), .lk(lk), .aa(aa),
        .li(li), .bd(bd), .bi(bi), .bo(bo), .bh(bh), .sc_lev(sc_lev),
        .cond_op(cond_op), .cr_ba(cr_ba), .cr_bb(cr_bb), .cr_bt(cr_bt)
    );

    fixed_point_decoder fixed_point_i (
        .clk(clk), .rst(rst), .instruction(instruction), .fx_execute(fx_execute),
        .op1_reg(op1_reg), .op2_reg(op2_reg), .result_reg(result_reg),
        .op2_use_imm(op2_use_imm), .op2_immediate(op2_immediate),
        .mb(mb), .me(me), .mask_insert(mask_insert),
        .subtract(subtract), .alter_ca(alter_ca), .alter_ov(alter_ov), .add_ca(add_ca),
        .alter_cr0(alter_cr0), .cmp_signed(cmp_signed), .bf(bf)
    );

endmodule

// ==== verification/tb_ppc_decode.sv ====
// decode stage testbench
`timescale 1ns/1ps

module tb_ppc_decode import ppc_decode_pkg::*; ();

    localparam int NUM_INSTR  = 2000;
    localparam int TIMEOUT_NS = (NUM_INSTR + 16) * 8;
    localparam int DRAIN_NS   = TIMEOUT_NS + 64;
    localparam int BR_W  = 6 + LI_W + BD_W + CR_BIT_W + BO_W + BH_W + LEV_W;
    localparam int CND_W = 3 + 3 * CR_BIT_W;
    localparam int FXO_W = 2 + 3 * REG_ADDR_W + 1 + DATA_W;
    localparam int ROT_W = 2 * SH_W + 2;
    localparam int ARI_W = 5 + CR_FIELD_W;

    localparam logic [XO_W-1:0] CR_XO [8] = '{XO_MCRF, XO_CRAND, XO_CROR, XO_CRXOR,
                                              XO_CRNOR, XO_CRANDC, XO_CRORC, XO_CREQV};
    localparam logic [XO_W-2:0] ARITH_XO [11] = '{XO_ADD, XO_ADDC, XO_ADDE, XO_ADDZE,
                                                  XO_ADDME, XO_SUBF, XO_SUBFC, XO_SUBFE,
                                                  XO_SUBFZE, XO_SUBFME, XO_NEG};

    typedef struct packed {
        branch_exec_t          br_exec;
        branch_op_t            br_op;
        logic                  lk, aa;
        logic [LI_W-1:0]       li;
        logic [BD_W-1:0]       bd;
        logic [CR_BIT_W-1:0]   bi;
        logic [BO_W-1:0]       bo;
        logic [BH_W-1:0]       bh;
        logic [LEV_W-1:0]      lev;
        cond_op_t              cond;
        logic [CR_BIT_W-1:0]   ba, bb, bt;
        fx_exec_t              fx_exec;
        logic [REG_ADDR_W-1:0] op1, op2, res;
        logic                  use_imm;
        logic [DATA_W-1:0]     imm;
        logic [SH_W-1:0]       mb, me;
        logic                  insert, cr0;
        logic                  sub, ca, ov, add_ca, cmp_s;
        logic [CR_FIELD_W-1:0] bf;
    } exp_t;

    logic                  clk = 1'b0;
    logic                  rst = 1'b1;
    logic [0:INSTR_W-1]    instruction = '0;
    branch_exec_t          branch_execute;
    branch_op_t            branch_op;
    cond_op_t              cond_op;
    fx_exec_t              fx_execute;
    logic                  lk, aa, op2_use_imm, mask_insert, alter_cr0;
    logic                  subtract, alter_ca, alter_ov, add_ca, cmp_signed;
    logic [LI_W-1:0]       li;
    logic [BD_W-1:0]       bd;
    logic [CR_BIT_W-1:0]   bi, cr_ba, cr_bb, cr_bt;
    logic [BO_W-1:0]       bo;
    logic [BH_W-1:0]       bh;
    logic [LEV_W-1:0]      sc_lev;
    logic [REG_ADDR_W-1:0] op1_reg, op2_reg, result_reg;
    logic [DATA_W-1:0]     op2_immediate;
    logic [SH_W-1:0]       mb, me;
    logic [CR_FIELD_W-1:0] bf;

    logic [0:INSTR_W-1]    prev_instr = '0;
    logic                  prev_rst = 1'b1;
    logic                  armed = 1'b0;
    int                    checked_cycles = 0;
    int                    n;
    exp_t                  exp_v;
    logic [BR_W-1:0]       act_br, exp_br;
    logic [CND_W-1:0]      act_cnd, exp_cnd;
    logic [FXO_W-1:0]      act_fxo, exp_fxo;
    logic [ROT_W-1:0]      act_rot, exp_rot;
    logic [ARI_W-1:0]      act_ari, exp_ari;

    ppc_decode_top dut_i (.*);

    always #4 clk = ~clk;

    function automatic exp_t ref_decode(input logic [0:INSTR_W-1] w, input logic in_reset);
        exp_t            e;
        logic [5:0]      opcd;
        logic [XO_W-1:0] xo10;
        logic [XO_W-2:0] xo9;
        logic            cr_hit, arith, extended, zero_imm, ones_imm;
        e        = '0;
        opcd     = w[0:5];
        xo10     = w[21:30];
        xo9      = w[22:30]; // OE is bit 21
        cr_hit   = 1'b1;
        arith    = xo9 inside {XO_ADD, XO_ADDC, XO_ADDE, XO_ADDZE, XO_ADDME, XO_SUBF,
                               XO_SUBFC, XO_SUBFE, XO_SUBFZE, XO_SUBFME, XO_NEG};
        extended = xo9 inside {XO_ADDE, XO_SUBFE, XO_ADDZE, XO_SUBFZE, XO_ADDME, XO_SUBFME};
        zero_imm = xo9 inside {XO_NEG, XO_ADDZE, XO_SUBFZE};
        ones_imm = xo9 inside {XO_ADDME, XO_SUBFME};
        if (!in_reset)
        begin
            case (opcd)
                OPCD_B:
                begin
                    e.br_exec = BR_EXEC_BRANCH;
                    {e.li, e.aa, e.lk} = w[6:31];
                end
                OPCD_BC:
                begin
                    e.br_exec = BR_EXEC_BRANCH;
                    e.br_op   = BRANCH_COND;
                    {e.bo, e.bi, e.bd, e.aa, e.lk} = w[6:31];
                end
                OPCD_SC:
                begin
                    if (w[30])
                    begin
                        e.br_exec = BR_EXEC_SYSCALL;
                        e.lev     = w[20:26];
                    end
                end
                OPCD_XL:
                begin
                    if (xo10 == XO_BCLR || xo10 == XO_BCCTR)
                    begin
                        e.br_exec = BR_EXEC_BRANCH;
                        e.br_op   = (xo10 == XO_BCLR) ? BRANCH_LR : BRANCH_CTR;
                        {e.bo, e.bi} = w[6:15];
                        e.bh = w[19:20];
                        e.lk = w[31];
                    end
                    else
                    begin
                        case (xo10)
                            XO_MCRF:   e.cond = COND_MOVE;
                            XO_CRAND:  e.cond = COND_AND;
                            XO_CROR:   e.cond = COND_OR;
                            XO_CRXOR:  e.cond = COND_XOR;
                            XO_CRNOR:  e.cond = COND_NOR;
                            XO_CRANDC: e.cond = COND_ANDC;
                            XO_CRORC:  e.cond = COND_ORC;
                            XO_CREQV:  e.cond = COND_EQV;
                            default:   cr_hit = 1'b0;
                        endcase
                        if (cr_hit)
                        begin
                            e.br_exec = BR_EXEC_COND;
                            {e.bt, e.ba, e.bb} = w[6:20];
                        end
                    end
                end
                OPCD_RLWIMI, OPCD_RLWINM, OPCD_RLWNM:
                begin
                    e.fx_exec = FX_EXEC_ROTATE;
                    {e.op1, e.res} = w[6:15];
                    {e.mb, e.me, e.cr0} = w[21:31];
                    e.insert = (opcd == OPCD_RLWIMI);
                    if (opcd == OPCD_RLWNM)
                        e.op2 = w[16:20];
                    else
                    begin
                        e.use_imm = 1'b1;
                        e.imm[SH_W-1:0] = w[16:20]; // SH, zero-extended
                    end
                end
                OPCD_X:
                begin
                    if (xo10 == XO_CMP || xo10 == XO_CMPL)
                    begin
                        e.fx_exec = FX_EXEC_COMPARE;
                        {e.op1, e.op2} = w[11:20];
                        e.cmp_s = (xo10 == XO_CMP);
                        e.bf    = w[6:8];
                    end
                    else if (arith)
                    begin
                        e.fx_exec = FX_EXEC_ADD_SUB;
                        e.res     = w[6:10];
                        e.op1     = w[11:15];
                        e.use_imm = zero_imm || ones_imm;
                        e.op2     = e.use_imm ? '0 : w[16:20];
                        e.imm     = ones_imm ? '1 : '0;
                        e.sub     = xo9 inside {XO_SUBF, XO_SUBFC, XO_SUBFE, XO_SUBFZE,
                                                XO_SUBFME, XO_NEG};
                        e.ca      = extended || xo9 inside {XO_ADDC, XO_SUBFC};
                        e.add_ca  = extended;
                        e.ov      = w[21];
                        e.cr0     = w[31];
                    end
                end
                default: ;
            endcase
        end
        return e;
    endfunction

    function automatic logic [0:INSTR_W-1] random_instruction();
        logic [0:INSTR_W-1] w;
        logic [5:0]         opcd;
        w = $urandom();
        case ($urandom_range(10, 0))
            0: w[0:5] = OPCD_B;
            1: w[0:5] = OPCD_BC;
            2: {w[0:5], w[21:30]} = {OPCD_XL, XO_BCLR};
            3: {w[0:5], w[21:30]} = {OPCD_XL, XO_BCCTR};
            4: {w[0:5], w[30]} = {OPCD_SC, 1'b1};
            5: {w[0:5], w[30]} = {OPCD_SC, 1'b0}; // always-one bit clear
            6: {w[0:5], w[21:30]} = {OPCD_XL, CR_XO[$urandom_range(7, 0)]};
            7: w[0:5] = ($urandom_range(2, 0) == 0) ? OPCD_RLWIMI :
                        ($urandom_range(1, 0) == 0) ? OPCD_RLWINM : OPCD_RLWNM;
            8: {w[0:5], w[22:30]} = {OPCD_X, ARITH_XO[$urandom_range(10, 0)]};
            9: {w[0:5], w[21:30]} = {OPCD_X, ($urandom_range(1, 0) == 0) ? XO_CMP : XO_CMPL};
            default:
            begin
                opcd = $urandom_range(63, 0);
                if (opcd inside {OPCD_BC, OPCD_SC, OPCD_B, OPCD_XL, OPCD_RLWIMI,
                                 OPCD_RLWINM, OPCD_RLWNM, OPCD_X})
                    opcd = opcd ^ 6'b100000; // lands on an unused opcode
                w[0:5] = opcd;
            end
        endcase
        return w;
    endfunction

    task automatic stop_failed();
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] expected,
                                   input logic [63:0] actual);
        $display("mismatch %s expected %h actual %h", name, expected, actual);
        stop_failed();
    endtask

    always @(posedge clk)
    begin
        prev_instr <= instruction;
        prev_rst   <= rst;
        armed      <= 1'b1;
        if (armed && !prev_rst)
            checked_cycles <= checked_cycles + 1;
    end

    assign exp_v   = ref_decode(prev_instr, prev_rst);
    assign act_br  = {branch_execute, branch_op, lk, aa, li, bd, bi, bo, bh, sc_lev};
    assign exp_br  = {exp_v.br_exec, exp_v.br_op, exp_v.lk, exp_v.aa, exp_v.li, exp_v.bd,
                      exp_v.bi, exp_v.bo, exp_v.bh, exp_v.lev};
    assign act_cnd = {cond_op, cr_ba, cr_bb, cr_bt};
    assign exp_cnd = {exp_v.cond, exp_v.ba, exp_v.bb, exp_v.bt};
    assign act_fxo = {fx_execute, op1_reg, op2_reg, result_reg, op2_use_imm, op2_immediate};
    assign exp_fxo = {exp_v.fx_exec, exp_v.op1, exp_v.op2, exp_v.res, exp_v.use_imm,
                      exp_v.imm};
    assign act_rot = {mb, me, mask_insert, alter_cr0};
    assign exp_rot = {exp_v.mb, exp_v.me, exp_v.insert, exp_v.cr0};
    assign act_ari = {subtract, alter_ca, alter_ov, add_ca, cmp_signed, bf};
    assign exp_ari = {exp_v.sub, exp_v.ca, exp_v.ov, exp_v.add_ca, exp_v.cmp_s, exp_v.bf};

    // each group one cycle after its instruction
    chk_branch: assert property (@(posedge clk) armed |-> act_br == exp_br)
        else report_mismatch("branch", $sampled(exp_br), $sampled(act_br));
    chk_cond: assert property (@(posedge clk) armed |-> act_cnd == exp_cnd)
        else report_mismatch("cond", $sampled(exp_cnd), $sampled(act_cnd));
    chk_operands: assert property (@(posedge clk) armed |-> act_fxo == exp_fxo)
        else report_mismatch("operands", $sampled(exp_fxo), $sampled(act_fxo));
    chk_rotate: assert property (@(posedge clk) armed |-> act_rot == exp_rot)
        else report_mismatch("rotate", $sampled(exp_rot), $sampled(act_rot));
    chk_arith: assert property (@(posedge clk) armed |-> act_ari == exp_ari)
        else report_mismatch("arith", $sampled(exp_ari), $sampled(act_ari));

    initial
    begin
        void'($urandom(3890));
        n = 0;
        while (n < 2 && $time < 64)
        begin
            @(negedge clk);
            n++;
        end
        rst = 1'b0;
        n = 0;
        while (n < NUM_INSTR && $time < TIMEOUT_NS)
        begin
            @(negedge clk);
            instruction = random_instruction();
            n++;
        end
        if (n < NUM_INSTR)
        begin
            $display("timeout before all instructions were driven");
            stop_failed();
        end
        n = 0;
        while (n < 2 && $time < DRAIN_NS)
        begin
            @(negedge clk);
            instruction = '0;
            n++;
        end
        if (checked_cycles >= NUM_INSTR)
        begin
            $display("TEST OK");
            $finish;
        end
        else
        begin
            $display("fewer cycles checked than instructions driven");
            stop_failed();
        end
    end

endmodule

// ==== ppc_decode.f ====
common/ppc_decode_pkg.sv
branch/branch_decoder.sv
fixed_point/fx_rotate_decoder.sv
fixed_point/fx_arith_decoder.sv
fixed_point/fixed_point_decoder.sv
design/ppc_decode_top.sv
verification/tb_ppc_decode.sv

// ==== Bender.yml ====
package:
  name: ppc_decode

sources:
  - files:
      - common/ppc_decode_pkg.sv
      - branch/branch_decoder.sv
      - fixed_point/fx_rotate_decoder.sv
      - fixed_point/fx_arith_decoder.sv
      - fixed_point/fixed_point_decoder.sv
      - design/ppc_decode_top.sv
  - target: test
    files:
      - verification/tb_ppc_decode.sv
